/* src/serial_link_pkg.sv */
// Serial link package with lane widths, register map and shared types
`default_nettype none

package serial_link_pkg;

  // Link dimensions
  localparam int NumLanes     = 8;
  localparam int WordWidth    = 32;
  localparam int BeatsPerWord = 4;
  localparam int RawFifoDepth = 4;
  localparam int ClkDivWidth  = 8;
  localparam int AddrWidth    = 5;

  typedef logic [NumLanes-1:0]             beat_t;
  typedef logic [WordWidth-1:0]            word_t;
  typedef logic [ClkDivWidth-1:0]          clk_div_t;
  typedef logic [$clog2(RawFifoDepth):0]   fill_t;
  typedef logic [AddrWidth-1:0]            apb_addr_t;

  // Forwarded clock divider limits
  localparam clk_div_t ClkDivReset = 8'd4;
  localparam clk_div_t ClkDivMin   = 8'd4;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  // CTRL bit 0 is raw_mode_en, bit 1 is raw_out_en
  localparam apb_addr_t RegCtrl         = 5'h00;
  localparam apb_addr_t RegClkDiv       = 5'h04;
  localparam apb_addr_t RegRawOutData   = 5'h08;
  localparam apb_addr_t RegRawOutStatus = 5'h0C;
  // Bit 8 valid, bits 7..0 data
  localparam apb_addr_t RegRawInData    = 5'h10;

endpackage

`default_nettype wire

/* src/serial_link_beat_if.sv */
// Beat channel with valid/ready handshake and a frame-end flag
`timescale 1ns/100ps
`default_nettype none

interface serial_link_beat_if
  import serial_link_pkg::*;
();

  beat_t beat;
  logic  valid;
  logic  ready;
  // Set on the final beat of a frame
  logic  last;

  modport src (
    output beat, valid, last,
    input  ready
  );

  modport dst (
    input  beat, valid, last,
    output ready
  );

endinterface

`default_nettype wire

/* src/serial_link_raw_if.sv */
// Raw-mode link between the register block and the raw FIFOs
`timescale 1ns/100ps
`default_nettype none

interface serial_link_raw_if
  import serial_link_pkg::*;
();

  // Transmit side
  logic  push;
  beat_t push_beat;
  logic  tx_full;
  fill_t tx_fill;

  // Receive side, rx_beat is the FIFO head
  logic  pop;
  beat_t rx_beat;
  logic  rx_valid;

  modport regs (
    output push, push_beat, pop,
    input  tx_full, tx_fill, rx_beat, rx_valid
  );

  modport fifo (
    input  push, push_beat, pop,
    output tx_full, tx_fill, rx_beat, rx_valid
  );

endinterface

`default_nettype wire

/* src/serial_link_regs.sv */
// APB register block for link control, clock divider and raw-mode access
`timescale 1ns/100ps
`default_nettype none

module serial_link_regs
  import serial_link_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  apb_addr_t   paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  serial_link_raw_if.regs raw_o,
  output logic        raw_mode_en_o,
  output logic        raw_out_en_o,
  output clk_div_t    clk_div_o
);

  logic     raw_mode_en_q;
  logic     raw_out_en_q;
  clk_div_t clk_div_q;
  clk_div_t new_div;
  logic     div_legal;
  logic     wr_en;
  logic     rd_en;
  beat_t    rx_data;

  // Zero wait states, access phase always completes
  assign pready_o = 1'b1;
  assign wr_en    = psel_i && penable_i && pwrite_i;
  assign rd_en    = psel_i && penable_i && !pwrite_i;

  // Divider must be even and at least the minimum
  assign new_div   = pwdata_i[ClkDivWidth-1:0];
  assign div_legal = !new_div[0] && (new_div >= ClkDivMin);

  // Raw FIFO strobes
  assign raw_o.push      = wr_en && (paddr_i == RegRawOutData) && !raw_o.tx_full;
  assign raw_o.push_beat = pwdata_i[NumLanes-1:0];
  assign raw_o.pop       = rd_en && (paddr_i == RegRawInData) && raw_o.rx_valid;

  assign rx_data = raw_o.rx_valid ? raw_o.rx_beat : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      raw_mode_en_q <= 1'b0;
      raw_out_en_q  <= 1'b0;
      clk_div_q     <= ClkDivReset;
    end else if (wr_en) begin
      if (paddr_i == RegCtrl) begin
        raw_mode_en_q <= pwdata_i[0];
        raw_out_en_q  <= pwdata_i[1];
      end
      // Illegal values leave the divider untouched
      if (paddr_i == RegClkDiv && div_legal) begin
        clk_div_q <= new_div;
      end
    end
  end

  // Read mux and error decode
  always_comb begin
    prdata_o  = '0;
    pslverr_o = 1'b0;
    case (paddr_i)
      RegCtrl:         prdata_o = {30'b0, raw_out_en_q, raw_mode_en_q};
      RegClkDiv: begin
        prdata_o  = 32'(clk_div_q);
        pslverr_o = pwrite_i && !div_legal;
      end
      RegRawOutData:   pslverr_o = pwrite_i && raw_o.tx_full;
      RegRawOutStatus: prdata_o = 32'(raw_o.tx_fill);
      RegRawInData:    prdata_o = {23'b0, raw_o.rx_valid, rx_data};
      default:         pslverr_o = 1'b1;
    endcase
  end

  assign raw_mode_en_o = raw_mode_en_q;
  assign raw_out_en_o  = raw_out_en_q;
  assign clk_div_o     = clk_div_q;

  // The phy relies on an even divider of at least the minimum
  a_clk_div_legal: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (clk_div_q >= ClkDivMin) && !clk_div_q[0]
  );

endmodule

`default_nettype wire

/* src/serial_link_raw_mode.sv */
// Raw-mode transmit and receive FIFOs between registers and the lanes
`timescale 1ns/100ps
`default_nettype none

module serial_link_raw_mode
  import serial_link_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  serial_link_raw_if.fifo raw_i,
  input  logic  out_en_i,
  input  logic  in_en_i,
  serial_link_beat_if.src tx_o,
  input  beat_t rx_beat_i,
  input  logic  rx_beat_valid_i
);

  typedef logic [$clog2(RawFifoDepth)-1:0] ptr_t;

  // Index 0 is the transmit FIFO, index 1 the receive FIFO
  logic  [1:0] push;
  logic  [1:0] pop;
  logic  [1:0] full;
  logic  [1:0] empty;
  beat_t [1:0] wdata;
  beat_t [1:0] head;
  fill_t [1:0] fill;

  for (genvar f = 0; f < 2; f++) begin : gen_fifo
    beat_t mem_q [RawFifoDepth];
    ptr_t  wr_ptr_q;
    ptr_t  rd_ptr_q;
    fill_t fill_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        fill_q   <= '0;
      end else begin
        if (push[f]) wr_ptr_q <= wr_ptr_q + ptr_t'(1);
        if (pop[f])  rd_ptr_q <= rd_ptr_q + ptr_t'(1);
        if (push[f] && !pop[f]) fill_q <= fill_q + fill_t'(1);
        if (pop[f] && !push[f]) fill_q <= fill_q - fill_t'(1);
      end
    end

    always_ff @(posedge clk_i) begin
      if (push[f]) mem_q[wr_ptr_q] <= wdata[f];
    end

    assign head[f]  = mem_q[rd_ptr_q];
    assign fill[f]  = fill_q;
    assign full[f]  = fill_q == fill_t'(RawFifoDepth);
    assign empty[f] = fill_q == '0;
  end

  ////////////////////////////////////////
  // Transmit FIFO
  ////////////////////////////////////////

  assign push[0]  = raw_i.push;
  assign wdata[0] = raw_i.push_beat;
  assign pop[0]   = tx_o.valid && tx_o.ready;

  // Every raw beat is a frame of its own
  assign tx_o.valid = out_en_i && !empty[0];
  assign tx_o.beat  = head[0];
  assign tx_o.last  = 1'b1;

  assign raw_i.tx_full = full[0];
  assign raw_i.tx_fill = fill[0];

  ////////////////////////////////////////
  // Receive FIFO
  ////////////////////////////////////////

  // Beats arriving while full are lost
  assign push[1]  = in_en_i && rx_beat_valid_i && !full[1];
  assign wdata[1] = rx_beat_i;
  assign pop[1]   = raw_i.pop && !empty[1];

  assign raw_i.rx_beat  = head[1];
  assign raw_i.rx_valid = !empty[1];

  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !(|(push & full))
  );

endmodule

`default_nettype wire

/* src/serial_link_framer.sv */
// Word framer, splits words into lane beats and rebuilds received words
`timescale 1ns/100ps
`default_nettype none

module serial_link_framer
  import serial_link_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  word_t tx_word_i,
  input  logic  tx_valid_i,
  output logic  tx_ready_o,
  serial_link_beat_if.src tx_o,
  input  beat_t rx_beat_i,
  input  logic  rx_beat_valid_i,
  input  logic  rx_en_i,
  output word_t rx_word_o,
  output logic  rx_valid_o
);

  typedef logic [$clog2(BeatsPerWord)-1:0] beat_cnt_t;

  ////////////////////////////////////////
  // Transmit, low beat first
  ////////////////////////////////////////

  word_t     tx_word_q;
  beat_cnt_t tx_cnt_q;
  logic      tx_busy_q;
  logic      tx_accept;
  logic      tx_fire;

  assign tx_ready_o = !tx_busy_q;
  assign tx_accept  = tx_valid_i && !tx_busy_q;
  assign tx_fire    = tx_o.valid && tx_o.ready;

  assign tx_o.valid = tx_busy_q;
  assign tx_o.beat  = tx_word_q[NumLanes-1:0];
  assign tx_o.last  = tx_cnt_q == beat_cnt_t'(BeatsPerWord - 1);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_busy_q <= 1'b0;
      tx_cnt_q  <= '0;
    end else if (tx_accept) begin
      tx_busy_q <= 1'b1;
      tx_cnt_q  <= '0;
    end else if (tx_fire) begin
      tx_cnt_q <= tx_cnt_q + beat_cnt_t'(1);
      if (tx_o.last) tx_busy_q <= 1'b0;
    end
  end

  // Shift the next beat into the low lanes
  always_ff @(posedge clk_i) begin
    if (tx_accept) begin
      tx_word_q <= tx_word_i;
    end else if (tx_fire) begin
      tx_word_q <= tx_word_q >> NumLanes;
    end
  end

  ////////////////////////////////////////
  // Receive
  ////////////////////////////////////////

  word_t     rx_word_q;
  beat_cnt_t rx_cnt_q;
  logic      rx_valid_q;
  logic      rx_take;

  assign rx_take = rx_en_i && rx_beat_valid_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_cnt_q   <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_valid_q <= rx_take && (rx_cnt_q == beat_cnt_t'(BeatsPerWord - 1));
      if (rx_take) rx_cnt_q <= rx_cnt_q + beat_cnt_t'(1);
    end
  end

  // First beat ends up in the low byte after four shifts
  always_ff @(posedge clk_i) begin
    if (rx_take) rx_word_q <= {rx_beat_i, rx_word_q[WordWidth-1:NumLanes]};
  end

  assign rx_word_o  = rx_word_q;
  assign rx_valid_o = rx_valid_q;

endmodule

`default_nettype wire

/* src/serial_link_tx_arbiter.sv */
// Round-robin arbiter for the transmit beat port, switches only between frames
`timescale 1ns/100ps
`default_nettype none

module serial_link_tx_arbiter
  import serial_link_pkg::*;
(
  input  logic clk_i,
  input  logic arst_n_i,
  serial_link_beat_if.dst framer_i,
  serial_link_beat_if.dst raw_i,
  serial_link_beat_if.src phy_o
);

  // Selection 0 is the framer, 1 is the raw source
  logic locked_q;
  logic grant_q;
  logic prio_q;
  logic sel;
  logic phy_fire;

  always_comb begin
    if (locked_q) begin
      sel = grant_q;
    end else if (framer_i.valid && raw_i.valid) begin
      sel = prio_q;
    end else begin
      sel = raw_i.valid;
    end
  end

  assign phy_o.valid = sel ? raw_i.valid : framer_i.valid;
  assign phy_o.beat  = sel ? raw_i.beat  : framer_i.beat;
  assign phy_o.last  = sel ? raw_i.last  : framer_i.last;

  assign framer_i.ready = phy_o.ready && !sel;
  assign raw_i.ready    = phy_o.ready && sel;

  assign phy_fire = phy_o.valid && phy_o.ready;

  // Hold the grant from the first offered beat until the frame ends
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      locked_q <= 1'b0;
      grant_q  <= 1'b0;
      prio_q   <= 1'b0;
    end else if (phy_o.valid) begin
      if (phy_fire && phy_o.last) begin
        locked_q <= 1'b0;
        prio_q   <= !sel;
      end else begin
        locked_q <= 1'b1;
        grant_q  <= sel;
      end
    end
  end

  a_grant_stable_in_frame: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (phy_fire && !phy_o.last) |=> (sel == $past(sel))
  );

endmodule

`default_nettype wire

/* src/serial_link_phy.sv */
// Physical layer with forwarded-clock transmitter and synchronizing receiver
`timescale 1ns/100ps
`default_nettype none

module serial_link_phy
  import serial_link_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  clk_div_t clk_div_i,
  serial_link_beat_if.dst tx_i,
  output beat_t    lanes_o,
  output logic     lane_clk_o,
  input  beat_t    lanes_i,
  input  logic     lane_clk_i,
  output beat_t    rx_beat_o,
  output logic     rx_beat_valid_o
);

  ////////////////////////////////////////
  // Transmit
  ////////////////////////////////////////

  clk_div_t cnt_q;
  clk_div_t cnt_d;
  logic     busy_q;
  logic     busy_d;
  logic     lane_clk_q;
  beat_t    lanes_q;
  logic     last_phase;
  logic     tx_fire;

  // One beat per clk_div_i cycles, next beat taken in the final cycle
  assign last_phase = cnt_q == (clk_div_i - clk_div_t'(1));
  assign tx_i.ready = !busy_q || last_phase;
  assign tx_fire    = tx_i.valid && tx_i.ready;

  always_comb begin
    busy_d = busy_q;
    cnt_d  = cnt_q + clk_div_t'(1);
    if (tx_fire) begin
      busy_d = 1'b1;
      cnt_d  = '0;
    end else if (!busy_q || last_phase) begin
      busy_d = 1'b0;
      cnt_d  = '0;
    end
  end

  // Low for the first half of a beat, high for the second
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q     <= 1'b0;
      cnt_q      <= '0;
      lane_clk_q <= 1'b0;
    end else begin
      busy_q     <= busy_d;
      cnt_q      <= cnt_d;
      lane_clk_q <= busy_d && (cnt_d >= (clk_div_i >> 1));
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_fire) lanes_q <= tx_i.beat;
  end

  assign lanes_o    = lanes_q;
  assign lane_clk_o = lane_clk_q;

  ////////////////////////////////////////
  // Receive
  ////////////////////////////////////////

  logic  clk_s1_q;
  logic  clk_s2_q;
  logic  clk_s3_q;
  beat_t lanes_s1_q;
  beat_t lanes_s2_q;
  beat_t rx_beat_q;
  logic  rx_valid_q;
  logic  rise;

  // Lanes follow the same two stages as the forwarded clock
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      clk_s1_q   <= 1'b0;
      clk_s2_q   <= 1'b0;
      clk_s3_q   <= 1'b0;
      rx_valid_q <= 1'b0;
    end else begin
      clk_s1_q   <= lane_clk_i;
      clk_s2_q   <= clk_s1_q;
      clk_s3_q   <= clk_s2_q;
      rx_valid_q <= rise;
    end
  end

  assign rise = clk_s2_q && !clk_s3_q;

  always_ff @(posedge clk_i) begin
    lanes_s1_q <= lanes_i;
    lanes_s2_q <= lanes_s1_q;
    if (rise) rx_beat_q <= lanes_s2_q;
  end

  assign rx_beat_o       = rx_beat_q;
  assign rx_beat_valid_o = rx_valid_q;

endmodule

`default_nettype wire

/* src/serial_link.sv */
// Serial link top level joining registers, framer, raw mode, arbiter and phy
`timescale 1ns/100ps
`default_nettype none

module serial_link
  import serial_link_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  apb_addr_t   paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  input  word_t       tx_word_i,
  input  logic        tx_valid_i,
  output logic        tx_ready_o,
  output word_t       rx_word_o,
  output logic        rx_valid_o,
  output beat_t       lanes_o,
  output logic        lane_clk_o,
  input  beat_t       lanes_i,
  input  logic        lane_clk_i
);

  serial_link_beat_if framer_tx ();
  serial_link_beat_if raw_tx ();
  serial_link_beat_if phy_tx ();
  serial_link_raw_if  raw_if ();

  logic     raw_mode_en;
  logic     raw_out_en;
  logic     rx_en;
  clk_div_t clk_div;
  beat_t    rx_beat;
  logic     rx_beat_valid;

  // Received beats go to the framer unless raw mode is on
  assign rx_en = !raw_mode_en;

  ////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////

  serial_link_regs i_regs (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .psel_i        ( psel_i      ),
    .penable_i     ( penable_i   ),
    .pwrite_i      ( pwrite_i    ),
    .paddr_i       ( paddr_i     ),
    .pwdata_i      ( pwdata_i    ),
    .prdata_o      ( prdata_o    ),
    .pready_o      ( pready_o    ),
    .pslverr_o     ( pslverr_o   ),
    .raw_o         ( raw_if      ),
    .raw_mode_en_o ( raw_mode_en ),
    .raw_out_en_o  ( raw_out_en  ),
    .clk_div_o     ( clk_div     )
  );

  ////////////////////////////////////////
  // Beat sources and arbitration
  ////////////////////////////////////////

  serial_link_raw_mode i_raw_mode (
    .clk_i           ( clk_i         ),
    .arst_n_i        ( arst_n_i      ),
    .raw_i           ( raw_if        ),
    .out_en_i        ( raw_out_en    ),
    .in_en_i         ( raw_mode_en   ),
    .tx_o            ( raw_tx        ),
    .rx_beat_i       ( rx_beat       ),
    .rx_beat_valid_i ( rx_beat_valid )
  );

  serial_link_framer i_framer (
    .clk_i           ( clk_i         ),
    .arst_n_i        ( arst_n_i      ),
    .tx_word_i       ( tx_word_i     ),
    .tx_valid_i      ( tx_valid_i    ),
    .tx_ready_o      ( tx_ready_o    ),
    .tx_o            ( framer_tx     ),
    .rx_beat_i       ( rx_beat       ),
    .rx_beat_valid_i ( rx_beat_valid ),
    .rx_en_i         ( rx_en         ),
    .rx_word_o       ( rx_word_o     ),
    .rx_valid_o      ( rx_valid_o    )
  );

  serial_link_tx_arbiter i_tx_arbiter (
    .clk_i    ( clk_i     ),
    .arst_n_i ( arst_n_i  ),
    .framer_i ( framer_tx ),
    .raw_i    ( raw_tx    ),
    .phy_o    ( phy_tx    )
  );

  ////////////////////////////////////////
  // Physical layer
  ////////////////////////////////////////

  serial_link_phy i_phy (
    .clk_i           ( clk_i         ),
    .arst_n_i        ( arst_n_i      ),
    .clk_div_i       ( clk_div       ),
    .tx_i            ( phy_tx        ),
    .lanes_o         ( lanes_o       ),
    .lane_clk_o      ( lane_clk_o    ),
    .lanes_i         ( lanes_i       ),
    .lane_clk_i      ( lane_clk_i    ),
    .rx_beat_o       ( rx_beat       ),
    .rx_beat_valid_o ( rx_beat_valid )
  );

endmodule

`default_nettype wire

/* sim/tb_serial_link.sv */
// Self-checking testbench that replays register and word patterns over a lane loopback
`timescale 1ns/100ps
`default_nettype none

module tb_serial_link
  import serial_link_pkg::*;
();

  localparam int    ApbTimeout   = 16;
  localparam int    WordTimeout  = 128;
  localparam int    DrainTimeout = 4000;
  // Gaps long enough for a raw beat to cross the loopback at any legal divider used
  localparam int    IdleMin      = 32;
  localparam int    IdleMax      = 63;
  localparam string PatternFile  = "sim/serial_link_patterns.txt";

  logic        clk_i;
  logic        arst_n_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  apb_addr_t   paddr_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        pslverr_o;
  word_t       tx_word_i;
  logic        tx_valid_i;
  logic        tx_ready_o;
  word_t       rx_word_o;
  logic        rx_valid_o;
  beat_t       lanes;
  logic        lane_clk;

  word_t exp_words[$];
  string test_name;
  int    tests;
  int    checks;
  int    errors;
  int    test_errors;
  logic  aborted;

  // Lanes and forwarded clock wrap straight back into the receiver
  serial_link u_dut (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .psel_i     ( psel_i     ),
    .penable_i  ( penable_i  ),
    .pwrite_i   ( pwrite_i   ),
    .paddr_i    ( paddr_i    ),
    .pwdata_i   ( pwdata_i   ),
    .prdata_o   ( prdata_o   ),
    .pready_o   ( pready_o   ),
    .pslverr_o  ( pslverr_o  ),
    .tx_word_i  ( tx_word_i  ),
    .tx_valid_i ( tx_valid_i ),
    .tx_ready_o ( tx_ready_o ),
    .rx_word_o  ( rx_word_o  ),
    .rx_valid_o ( rx_valid_o ),
    .lanes_o    ( lanes      ),
    .lane_clk_o ( lane_clk   ),
    .lanes_i    ( lanes      ),
    .lane_clk_i ( lane_clk   )
  );

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic check_apb_data(input apb_addr_t addr, input logic [31:0] got_data,
                                input logic got_err, input logic [31:0] exp_data,
                                input logic exp_err, input logic is_read);
    checks++;
    if (is_read && got_data !== exp_data) begin
      report_error($sformatf("read of 0x%02h returned 0x%08h, expected 0x%08h",
                             addr, got_data, exp_data));
    end
    if (got_err !== exp_err) begin
      report_error($sformatf("pslverr at 0x%02h was %0b, expected %0b", addr, got_err, exp_err));
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("received word 0x%08h, expected 0x%08h", got, exp));
    end
  endtask

  // Received words are compared in order against the send queue
  always @(negedge clk_i) begin
    if (arst_n_i && rx_valid_o) begin
      if (exp_words.size() == 0) begin
        report_error($sformatf("unexpected word 0x%08h", rx_word_o));
      end else begin
        check_word(rx_word_o, exp_words.pop_front());
      end
    end
  end

  ////////////////////////////////////////
  // Bus and stream drivers
  ////////////////////////////////////////

  task automatic idle_gap();
    repeat ($urandom_range(IdleMax, IdleMin)) @(negedge clk_i);
  endtask

  task automatic apb_access(input apb_addr_t addr, input logic [31:0] wdata,
                            input logic write, output logic [31:0] rdata, output logic err);
    int waited;
    waited    = 0;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;
    #1;
    while (!pready_o && waited < ApbTimeout) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    rdata = prdata_o;
    err   = pslverr_o;
    if (!pready_o) begin
      $display("Timeout: APB access to 0x%02h never completed", addr);
      aborted = 1'b1;
    end else begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic send_word(input word_t word);
    int waited;
    waited     = 0;
    tx_word_i  = word;
    tx_valid_i = 1'b1;
    while (!tx_ready_o && waited < WordTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (!tx_ready_o) begin
      $display("Timeout: word 0x%08h was never accepted", word);
      aborted = 1'b1;
    end else begin
      @(posedge clk_i);
      exp_words.push_back(word);
    end
    @(negedge clk_i);
    tx_valid_i = 1'b0;
  endtask

  task automatic wait_words();
    int waited;
    waited = 0;
    while (exp_words.size() != 0 && waited < DrainTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_words.size() != 0) begin
      $display("Timeout: %0d expected words never arrived", exp_words.size());
      aborted = 1'b1;
    end
  endtask

  task automatic finish_test();
    if (test_name != "") begin
      tests++;
      if (test_errors == 0 && !aborted) begin
        $display("Test %-16s ok", test_name);
      end else begin
        $display("Test %-16s FAILED with %0d errors", test_name, test_errors);
      end
    end
  endtask

  ////////////////////////////////////////
  // Pattern replay
  ////////////////////////////////////////

  initial begin
    int               fd;
    int               code;
    int               rnd;
    logic [7:0]       cmd;
    logic [31:0]      addr_f;
    logic [31:0]      data_f;
    logic [31:0]      err_f;
    logic [8*32-1:0]  name_f;
    logic [8*128-1:0] skip_line;
    logic [31:0]      rdata;
    logic             err;
    clk_i      = 1'b0;
    arst_n_i   = 1'b0;
    psel_i     = 1'b0;
    penable_i  = 1'b0;
    pwrite_i   = 1'b0;
    paddr_i    = '0;
    pwdata_i   = '0;
    tx_word_i  = '0;
    tx_valid_i = 1'b0;
    aborted    = 1'b0;
    test_name  = "";
    rnd        = $urandom(32'h2654);
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    fd = $fopen(PatternFile, "r");
    if (fd == 0) begin
      $display("Could not open the pattern file %s", PatternFile);
      aborted = 1'b1;
    end
    while (fd != 0 && !aborted) begin
      code = $fscanf(fd, " %c", cmd);
      if (code != 1) break;
      case (cmd)
        "#": code = $fgets(skip_line, fd);
        "T": begin
          code = $fscanf(fd, "%s", name_f);
          finish_test();
          test_name   = $sformatf("%0s", name_f);
          test_errors = 0;
        end
        "W", "R": begin
          code = $fscanf(fd, "%h %h %h", addr_f, data_f, err_f);
          if (code != 3) begin
            $display("Pattern line for command %c is incomplete", cmd);
            aborted = 1'b1;
          end else begin
            idle_gap();
            apb_access(apb_addr_t'(addr_f), data_f, cmd == "W", rdata, err);
            if (!aborted) begin
              check_apb_data(apb_addr_t'(addr_f), rdata, err, data_f, err_f[0], cmd == "R");
            end
          end
        end
        "S": begin
          code = $fscanf(fd, "%h", data_f);
          idle_gap();
          send_word(word_t'(data_f));
        end
        "E": wait_words();
        default: begin
          $display("Unknown command %c in the pattern file", cmd);
          aborted = 1'b1;
        end
      endcase
    end
    if (fd != 0) $fclose(fd);

    finish_test();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0 && !aborted && checks > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/serial_link_patterns.txt */
# W addr data err : APB write, R addr data err : APB read with expected data (hex fields)
# S word : send a word, E : wait for all sent words, T name : start a test
T reset_values
R 00 00000000 0
R 04 00000004 0
R 0C 00000000 0
R 10 00000000 0
T register_errors
R 14 00000000 1
W 1C 00000000 1
W 04 00000003 1
R 04 00000004 0
W 04 00000005 1
R 04 00000004 0
W 04 00000006 0
R 04 00000006 0
T word_loopback
W 00 00000000 0
W 04 00000004 0
S 03020100
S DEADBEEF
S 0F1E2D3C
E
W 04 00000006 0
S 89ABCDEF
S 00000000
S FFFFFFFF
E
T raw_loopback
W 00 00000003 0
W 08 0000005A 0
W 08 000000C3 0
W 08 00000017 0
R 10 0000015A 0
R 10 000001C3 0
R 10 00000117 0
R 10 00000000 0
T raw_fifo_limits
W 00 00000001 0
W 08 000000A0 0
W 08 000000A1 0
W 08 000000A2 0
W 08 000000A3 0
R 0C 00000004 0
W 08 000000A4 1
R 0C 00000004 0
W 00 00000003 0
R 0C 00000000 0
R 10 000001A0 0
R 10 000001A1 0
R 10 000001A2 0
R 10 000001A3 0
R 10 00000000 0

/* sources.f */
src/serial_link_pkg.sv
src/serial_link_beat_if.sv
src/serial_link_raw_if.sv
src/serial_link_regs.sv
src/serial_link_raw_mode.sv
src/serial_link_framer.sv
src/serial_link_tx_arbiter.sv
src/serial_link_phy.sv
src/serial_link.sv
sim/tb_serial_link.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the serial link testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
BIN=Vtb_serial_link

verilator --binary --assert -f sources.f --top-module tb_serial_link \
  -Mdir "$BUILD_DIR" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
